//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_ahb_sram
FILELIST  := ahb_sram.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- ahb_sram.f
+incdir+include
hw/ahb_sram_pkg.sv
hw/byte_lane_decode.sv
hw/byte_lane_ram.sv
hw/ahb_sram_ctrl.sv
hw/ahb_sram_top.sv
dv/ahb_sram_asserts.sv
dv/tb_ahb_sram.sv

//--- dv/ahb_sram_asserts.sv
`timescale 1ns/1ps

module ahb_sram_asserts (
  input logic                      hclk,
  input logic                      hrst_b,
  input logic                      hready,
  input ahb_sram_pkg::hresp_t      hresp,
  input ahb_sram_pkg::lane_mask_t  lane_wen,
  input ahb_sram_pkg::ctrl_state_t state
);

  import ahb_sram_pkg::*;

  a_hresp_okay: assert property (@(posedge hclk) disable iff (!hrst_b)
    hresp == RESP_OKAY)
    else $error("hresp is not OKAY");

  // A hazard costs exactly one wait state.
  a_single_wait: assert property (@(posedge hclk) disable iff (!hrst_b)
    !hready |=> hready)
    else $error("hready low for two cycles in a row");

  a_wen_in_write: assert property (@(posedge hclk) disable iff (!hrst_b)
    (state != ST_WRITE) |-> (lane_wen == '0))
    else $error("lane write enable outside a write data phase");

endmodule

bind ahb_sram_ctrl ahb_sram_asserts u_asserts (
  .hclk     (hclk),
  .hrst_b   (hrst_b),
  .hready   (hready),
  .hresp    (hresp),
  .lane_wen (lane_wen),
  .state    (state)
);

//--- include/tb_lfsr.svh
`ifndef TB_LFSR_SVH
`define TB_LFSR_SVH

localparam logic [31:0] LFSR_SEED = 32'he90f;

// Galois form of x^32 + x^22 + x^2 + x + 1.
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// Takes n bits with one step per bit.
function automatic logic [31:0] lfsr_bits(inout logic [31:0] s, input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++)
  begin
    v = {v[30:0], s[0]};
    s = lfsr_step(s);
  end
  return v;
endfunction

function automatic int lfsr_pick(inout logic [31:0] s, input int n);
  return int'(lfsr_bits(s, 16)) % n;
endfunction

`endif

//--- dv/tb_ahb_sram.sv
`timescale 1ns/1ps

module tb_ahb_sram;

  import ahb_sram_pkg::*;

  `include "tb_lfsr.svh"

  localparam int      ADDR_W     = 8;
  localparam int      MEM_BYTES  = 1 << ADDR_W;
  localparam int      CLK_PERIOD = 100;
  localparam int      N_SIZED    = 40;
  localparam int      N_READS    = 40;
  localparam int      N_RAW      = 24;
  localparam int      N_MIXED    = 300;
  localparam int      ISSUES     = 40 + 3*N_SIZED + 2*N_READS + 3*N_RAW + N_MIXED;
  localparam int      WDOG_TIME  = (ISSUES*4 + 200) * CLK_PERIOD;
  localparam htrans_t TRANS_IDLE = 2'b00;

  logic              hclk;
  logic              hrst_b;
  logic              hsel;
  logic [ADDR_W-1:0] haddr;
  htrans_t           htrans;
  hsize_t            hsize;
  logic              hwrite;
  data_t             hwdata;
  data_t             hrdata;
  logic              hready;
  hresp_t            hresp;

  byte_t             model_mem [MEM_BYTES];
  logic [31:0]       rng;
  int                pass_cnt;
  int                fail_cnt;
  int                stall_cnt;
  int                test_base;
  logic              pend_valid;  // Transfer in its data phase.
  logic              pend_wr;
  logic [ADDR_W-1:0] pend_addr;
  hsize_t            pend_size;
  data_t             pend_wdata;
  logic              stall_due;

  ahb_sram_top #(
    .ADDR_W (ADDR_W)
  ) uut (
    .hclk   (hclk),
    .hrst_b (hrst_b),
    .hsel   (hsel),
    .haddr  (haddr),
    .htrans (htrans),
    .hsize  (hsize),
    .hwrite (hwrite),
    .hwdata (hwdata),
    .hrdata (hrdata),
    .hready (hready),
    .hresp  (hresp)
  );

  always #(CLK_PERIOD/2) hclk = ~hclk;

  function automatic logic [ADDR_W-1:0] align_addr(input logic [ADDR_W-1:0] a, input hsize_t sz);
    return a & ~((ADDR_W'(1) << sz) - ADDR_W'(1));
  endfunction

  function automatic data_t model_row(input logic [ADDR_W-1:0] a);
    data_t d;
    int    base;
    base = int'(a) & ~(LANES-1);
    for (int i = 0; i < LANES; i++)
      d[i*8 +: 8] = model_mem[base+i];
    return d;
  endfunction

  task automatic model_write(input logic [ADDR_W-1:0] a, input hsize_t sz, input data_t wd);
    int base;
    int lane;
    base = int'(align_addr(a, sz));
    for (int i = 0; i < (1 << sz); i++)
    begin
      lane = (base + i) % LANES;
      model_mem[base+i] = wd[lane*8 +: 8];
    end
  endtask

  task automatic check_value(input string name, input data_t exp, input data_t act);
    assert (act === exp) pass_cnt++;
    else
    begin
      $display("CHECK FAILED at %0t ns: %s expected %0h actual %0h", $time, name, exp, act);
      fail_cnt++;
    end
  endtask

  // One transfer from the falling edge until its address phase is taken.
  task automatic issue(input logic sel, input htrans_t trans, input logic wr, input hsize_t sz,
                       input logic [ADDR_W-1:0] addr, input data_t wd);
    logic done;
    done = 1'b0;
    hsel   = sel;
    htrans = trans;
    hwrite = wr;
    hsize  = sz;
    haddr  = addr;
    if (pend_valid && pend_wr)
      hwdata = pend_wdata;
    while (!done)
    begin
      check_value("hready", data_t'(!stall_due), data_t'(hready));
      check_value("hresp", data_t'(RESP_OKAY), data_t'(hresp));
      if (hready)
      begin
        if (pend_valid && pend_wr)
          model_write(pend_addr, pend_size, pend_wdata);
        else if (pend_valid)
          check_value("hrdata", model_row(pend_addr), hrdata);
        stall_due  = sel && trans[1] && !wr && pend_valid && pend_wr;  // Read meets write.
        pend_valid = sel && trans[1];
        pend_wr    = wr;
        pend_addr  = addr;
        pend_size  = sz;
        pend_wdata = wd;
        done       = 1'b1;
      end
      else
      begin
        stall_due = 1'b0;
        stall_cnt++;
      end
      @(negedge hclk);
    end
  endtask

  task automatic idle_cycle();
    issue(1'b1, TRANS_IDLE, 1'b0, SIZE_BYTE, '0, '0);
  endtask

  function automatic data_t rand_data();
    data_t d;
    for (int i = 0; i < 4; i++)
      d[i*32 +: 32] = lfsr_bits(rng, 32);
    return d;
  endfunction

  function automatic htrans_t rand_trans();
    return lfsr_bits(rng, 1) ? TRANS_SEQ : TRANS_NONSEQ;
  endfunction

  task automatic rand_write(output logic [ADDR_W-1:0] a);
    hsize_t sz;
    sz = hsize_t'(lfsr_pick(rng, 5));
    a  = align_addr(ADDR_W'(lfsr_bits(rng, ADDR_W)), sz);
    issue(1'b1, rand_trans(), 1'b1, sz, a, rand_data());
  endtask

  task automatic rand_read(input logic [ADDR_W-1:0] a);
    hsize_t sz;
    sz = hsize_t'(lfsr_pick(rng, 5));
    issue(1'b1, rand_trans(), 1'b0, sz, align_addr(a, sz), '0);
  endtask

  task automatic end_test(input string name);
    $display("Test %s done: %0d failures", name, fail_cnt - test_base);
    test_base = fail_cnt;
  endtask

  initial
  begin
    #(WDOG_TIME);
    $display("Watchdog expired before all transfers completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    logic [ADDR_W-1:0] a;
    int                stalls;
    int                kind;
    hclk       = 1'b0;
    hrst_b     = 1'b0;
    hsel       = 1'b0;
    haddr      = '0;
    htrans     = TRANS_IDLE;
    hsize      = SIZE_BYTE;
    hwrite     = 1'b0;
    hwdata     = '0;
    rng        = LFSR_SEED;
    pass_cnt   = 0;
    fail_cnt   = 0;
    stall_cnt  = 0;
    test_base  = 0;
    pend_valid = 1'b0;
    pend_wr    = 1'b0;
    pend_addr  = '0;
    pend_size  = SIZE_BYTE;
    pend_wdata = '0;
    stall_due  = 1'b0;
    for (int i = 0; i < MEM_BYTES; i++)
      model_mem[i] = '0;
    repeat (3) @(negedge hclk);
    hrst_b = 1'b1;
    @(negedge hclk);

    check_value("hready", data_t'(1), data_t'(hready));
    for (int r = 0; r < MEM_BYTES/LANES; r++)
      issue(1'b1, TRANS_NONSEQ, 1'b1, SIZE_QWORD, ADDR_W'(r*LANES), rand_data());
    idle_cycle();
    for (int r = 0; r < MEM_BYTES/LANES; r++)
      issue(1'b1, TRANS_NONSEQ, 1'b0, SIZE_QWORD, ADDR_W'(r*LANES), '0);
    idle_cycle();
    end_test("reset_values");

    repeat (N_SIZED)
    begin
      rand_write(a);
      idle_cycle();
      issue(1'b1, TRANS_NONSEQ, 1'b0, SIZE_QWORD, align_addr(a, SIZE_QWORD), '0);
    end
    idle_cycle();
    end_test("sized_writes");

    repeat (N_READS)
    begin
      if (lfsr_bits(rng, 1) != 0)
        idle_cycle();
      rand_read(ADDR_W'(lfsr_bits(rng, ADDR_W)));
    end
    idle_cycle();
    end_test("reads");

    stalls = stall_cnt;
    for (int n = 0; n < N_RAW; n++)
    begin
      rand_write(a);
      if (n % 2 == 0)
        rand_read(a);
      else
        rand_read(a ^ ADDR_W'((lfsr_pick(rng, 15) + 1) << LANE_SEL_W));  // Another row.
      idle_cycle();
    end
    check_value("stall cycles", data_t'(N_RAW), data_t'(stall_cnt - stalls));
    end_test("read_after_write");

    repeat (N_MIXED)
    begin
      kind = lfsr_pick(rng, 8);
      if (kind == 0)
        idle_cycle();
      else if (kind == 1)
        issue(1'b0, TRANS_NONSEQ, lfsr_bits(rng, 1) != 0, SIZE_WORD, '0, rand_data());
      else if (kind < 5)
        rand_read(ADDR_W'(lfsr_bits(rng, ADDR_W)));
      else
        rand_write(a);
    end
    idle_cycle();
    end_test("mixed_traffic");

    $display("Checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- hw/ahb_sram_ctrl.sv
`timescale 1ns/1ps

module ahb_sram_ctrl #(
  parameter int ADDR_W = 12
) (
  input  logic                                       hclk,
  input  logic                                       hrst_b,
  input  logic                                       hsel,
  input  logic [ADDR_W-1:0]                          haddr,
  input  ahb_sram_pkg::htrans_t                      htrans,
  input  ahb_sram_pkg::hsize_t                       hsize,
  input  logic                                       hwrite,
  input  ahb_sram_pkg::data_t                        hwdata,
  output logic                                       hready,
  output ahb_sram_pkg::hresp_t                       hresp,
  output logic [ADDR_W-ahb_sram_pkg::LANE_SEL_W-1:0] ram_addr,
  output ahb_sram_pkg::data_t                        ram_wdata,
  output ahb_sram_pkg::lane_mask_t                   lane_wen
);

  import ahb_sram_pkg::*;

  localparam int ROW_W = ADDR_W - LANE_SEL_W;

  ctrl_state_t      state;
  ctrl_state_t      next_state;
  logic             trans_valid;
  logic             wr_accept;
  logic             rd_accept;
  logic             raw_stall;
  logic [ROW_W-1:0] row_q;    // Row of the transfer in its data phase.
  lane_mask_t       wmask;
  lane_mask_t       wmask_q;

  assign trans_valid = hsel && hready &&
                       ((htrans == TRANS_NONSEQ) || (htrans == TRANS_SEQ));
  assign wr_accept   = trans_valid && hwrite;
  assign rd_accept   = trans_valid && !hwrite;

  // RAM port is taken by the write, so the read cannot be issued in time.
  assign raw_stall = rd_accept && (state == ST_WRITE);

  byte_lane_decode u_decode (
    .hsize     (hsize),
    .lane_addr (haddr[LANE_SEL_W-1:0]),
    .lane_mask (wmask)
  );

  always_comb
  begin
    case (state)
      ST_WRITE:
      begin
        if (wr_accept)
          next_state = ST_WRITE;
        else if (rd_accept)
          next_state = ST_STALL;
        else
          next_state = ST_IDLE;
      end
      ST_STALL:
        next_state = ST_IDLE;  // Nothing is accepted while hready is low.
      default:
        next_state = wr_accept ? ST_WRITE : ST_IDLE;
    endcase
  end

  always_ff @(posedge hclk or negedge hrst_b)
  begin
    if (!hrst_b)
      state <= ST_IDLE;
    else
      state <= next_state;
  end

  always_ff @(posedge hclk or negedge hrst_b)
  begin
    if (!hrst_b)
      hready <= 1'b0;
    else
      hready <= !raw_stall;  // One wait state per hazard.
  end

  always_ff @(posedge hclk)
  begin
    if (trans_valid)
      row_q <= haddr[ADDR_W-1:LANE_SEL_W];
    if (wr_accept)
      wmask_q <= wmask;
  end

  // Idle uses the live address so a read lands on the next edge.
  assign ram_addr  = (state == ST_IDLE) ? haddr[ADDR_W-1:LANE_SEL_W] : row_q;
  assign ram_wdata = hwdata;
  assign lane_wen  = (state == ST_WRITE) ? wmask_q : '0;
  assign hresp     = RESP_OKAY;

endmodule

//--- hw/ahb_sram_pkg.sv
package ahb_sram_pkg;

  localparam int DATA_W     = 128;
  localparam int LANES      = 16;
  localparam int LANE_SEL_W = 4;  // Byte offset inside one bus row.

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [7:0]        byte_t;
  typedef logic [LANES-1:0]  lane_mask_t;
  typedef logic [2:0]        hsize_t;
  typedef logic [1:0]        htrans_t;
  typedef logic [1:0]        hresp_t;

  // Size codes for transfers of 2**code bytes.
  localparam hsize_t SIZE_BYTE  = 3'd0;
  localparam hsize_t SIZE_HWORD = 3'd1;
  localparam hsize_t SIZE_WORD  = 3'd2;
  localparam hsize_t SIZE_DWORD = 3'd3;
  localparam hsize_t SIZE_QWORD = 3'd4;

  localparam htrans_t TRANS_NONSEQ = 2'b10;
  localparam htrans_t TRANS_SEQ    = 2'b11;

  localparam hresp_t RESP_OKAY = 2'b00;

  typedef enum logic [1:0]
  {
    ST_IDLE,   // No write data phase pending.
    ST_WRITE,  // Write data phase with the lanes busy.
    ST_STALL   // Read retried from the captured address.
  } ctrl_state_t;

endpackage

//--- hw/ahb_sram_top.sv
`timescale 1ns/1ps

module ahb_sram_top #(
  parameter int ADDR_W = 12
) (
  input  logic                  hclk,
  input  logic                  hrst_b,
  input  logic                  hsel,
  input  logic [ADDR_W-1:0]     haddr,
  input  ahb_sram_pkg::htrans_t htrans,
  input  ahb_sram_pkg::hsize_t  hsize,
  input  logic                  hwrite,
  input  ahb_sram_pkg::data_t   hwdata,
  output ahb_sram_pkg::data_t   hrdata,
  output logic                  hready,
  output ahb_sram_pkg::hresp_t  hresp
);

  import ahb_sram_pkg::*;

  localparam int BYTE_BITS = $bits(byte_t);

  logic [ADDR_W-LANE_SEL_W-1:0] ram_addr;
  data_t                        ram_wdata;
  lane_mask_t                   lane_wen;
  byte_t                        lane_rdata [LANES];

  ahb_sram_ctrl #(
    .ADDR_W (ADDR_W)
  ) u_ctrl (
    .hclk      (hclk),
    .hrst_b    (hrst_b),
    .hsel      (hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hsize     (hsize),
    .hwrite    (hwrite),
    .hwdata    (hwdata),
    .hready    (hready),
    .hresp     (hresp),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .lane_wen  (lane_wen)
  );

  for (genvar i = 0; i < LANES; i++)
  begin : g_lane
    byte_lane_ram #(
      .ADDR_W (ADDR_W)
    ) u_lane (
      .hclk  (hclk),
      .addr  (ram_addr),
      .wdata (ram_wdata[i*BYTE_BITS +: BYTE_BITS]),
      .wen   (lane_wen[i]),
      .rdata (lane_rdata[i])
    );
  end

  // Lane 0 is the lowest byte.
  always_comb
  begin
    for (int i = 0; i < LANES; i++)
      hrdata[i*BYTE_BITS +: BYTE_BITS] = lane_rdata[i];
  end

endmodule

//--- hw/byte_lane_decode.sv
`timescale 1ns/1ps

module byte_lane_decode (
  input  ahb_sram_pkg::hsize_t                 hsize,
  input  logic [ahb_sram_pkg::LANE_SEL_W-1:0]  lane_addr,
  output ahb_sram_pkg::lane_mask_t             lane_mask
);

  import ahb_sram_pkg::*;

  logic [LANE_SEL_W-1:0] match_bits;  // Address bits a lane must share with lane_addr.
  logic                  size_ok;

  assign size_ok = (hsize <= SIZE_QWORD);

  always_comb
  begin
    case (hsize)
      SIZE_BYTE:
        match_bits = 4'b1111;
      SIZE_HWORD:
        match_bits = 4'b1110;
      SIZE_WORD:
        match_bits = 4'b1100;
      SIZE_DWORD:
        match_bits = 4'b1000;
      SIZE_QWORD:
        match_bits = 4'b0000;  // Whole row.
      default:
        match_bits = 4'b0000;  // Masked off by size_ok.
    endcase
  end

  // A lane is enabled when it sits in the aligned group holding lane_addr.
  for (genvar i = 0; i < LANES; i++)
  begin : g_lane
    localparam logic [LANE_SEL_W-1:0] LANE_IDX = LANE_SEL_W'(i);

    assign lane_mask[i] = size_ok &&
                          (((LANE_IDX ^ lane_addr) & match_bits) == '0);
  end

endmodule

//--- hw/byte_lane_ram.sv
`timescale 1ns/1ps

module byte_lane_ram #(
  parameter int ADDR_W = 12
) (
  input  logic                                       hclk,
  input  logic [ADDR_W-ahb_sram_pkg::LANE_SEL_W-1:0] addr,
  input  ahb_sram_pkg::byte_t                        wdata,
  input  logic                                       wen,
  output ahb_sram_pkg::byte_t                        rdata
);

  import ahb_sram_pkg::*;

  localparam int DEPTH = 1 << (ADDR_W - LANE_SEL_W);

  byte_t mem [DEPTH];

  // Single port that returns old data on a write cycle.
  always_ff @(posedge hclk)
  begin
    if (wen)
      mem[addr] <= wdata;
    rdata <= mem[addr];
  end

endmodule
